// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		opcode_e opcode;
	} r_format_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		opcode_e opcode;
	} i_format_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e opcode;
	} s_format_t;

	// branch offset is scattered, bit 0 implied zero
	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		opcode_e opcode;
	} b_format_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		reg_addr_t rd;
		opcode_e opcode;
	} j_format_t;

	typedef union packed {
		r_format_t r_format;
		i_format_t i_format;
		s_format_t s_format;
		b_format_t b_format;
		j_format_t j_format;
	} instr_u;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic branch;
		logic link;
		logic alu_src_imm;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instr_u instr;
	} ifid_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		ctrl_t ctrl;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t rs1_data;
		word_t rs2_data;
		word_t imm;
	} idex_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		reg_addr_t rd;
		word_t result;
		word_t store_data;
	} exmem_t;

	typedef struct packed {
		logic valid;
		logic reg_write;
		reg_addr_t rd;
		word_t wb_data;
	} memwb_t;

	typedef struct packed {
		logic valid;
		word_t target;
	} redirect_t;

endpackage

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
	parameter cpu_pkg::word_t reset_pc = 32'h0000_0000
) (
	input logic clock,
	input logic reset,
	input logic stall,
	input cpu_pkg::redirect_t id_redirect,
	input cpu_pkg::redirect_t ex_redirect,
	output cpu_pkg::word_t instr_addr,
	input cpu_pkg::word_t instr_data,
	output cpu_pkg::ifid_t ifid
);
	import cpu_pkg::*;

	word_t pc;
	word_t pc_next;
	logic bubble;

	assign instr_addr = pc;

	// taken beq beats the load-use hold, which beats jal
	always_comb begin
		pc_next = pc + 32'd4;
		bubble = 1'b0;
		if (ex_redirect.valid) begin
			pc_next = ex_redirect.target;
			bubble = 1'b1;
		end else if (stall) begin
			pc_next = pc;
		end else if (id_redirect.valid) begin
			pc_next = id_redirect.target;
			bubble = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
			ifid.valid <= 1'b0;
			ifid.pc <= '0;
			ifid.instr <= nop_instr;
		end else begin
			pc <= pc_next;
			if (bubble) begin
				ifid.valid <= 1'b0;
				ifid.instr <= nop_instr;
			end else if (!stall) begin
				ifid.valid <= 1'b1;
				ifid.pc <= pc;
				ifid.instr <= instr_data;
			end
		end
	end

	// redirect targets come from decode and execute
	pc_aligned: assert property (@(posedge clock) disable iff (!reset) pc[1:0] == 2'b00);

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input logic clock,
	input logic reset,
	input cpu_pkg::ifid_t ifid,
	input cpu_pkg::redirect_t ex_redirect,
	input cpu_pkg::memwb_t memwb,
	output cpu_pkg::idex_t idex,
	output logic stall,
	output cpu_pkg::redirect_t id_redirect
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	word_t imm;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	logic uses_rs1;
	logic uses_rs2;
	logic wb_en;
	word_t rs1_data;
	word_t rs2_data;
	word_t register_file [32];

	// register fields sit at the same place in every format that has them
	assign rs1 = ifid.instr.r_format.rs1;
	assign rs2 = ifid.instr.r_format.rs2;
	assign rd = ifid.instr.r_format.rd;

	always_comb begin
		ctrl = '0;
		imm = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		if (ifid.valid) begin
			case (ifid.instr.r_format.opcode)
				opc_op: begin
					ctrl.reg_write = 1'b1;
					uses_rs1 = 1'b1;
					uses_rs2 = 1'b1;
					case (ifid.instr.r_format.funct3)
						3'b000: begin
							if (ifid.instr.r_format.funct7[5]) begin
								ctrl.alu_op = alu_sub;
							end else begin
								ctrl.alu_op = alu_add;
							end
						end
						3'b010: ctrl.alu_op = alu_slt;
						3'b100: ctrl.alu_op = alu_xor;
						3'b110: ctrl.alu_op = alu_or;
						3'b111: ctrl.alu_op = alu_and;
						default: ctrl.alu_op = alu_add;
					endcase
				end
				opc_op_imm, opc_load: begin
					ctrl.reg_write = 1'b1;
					ctrl.mem_read = (ifid.instr.r_format.opcode == opc_load);
					ctrl.alu_src_imm = 1'b1;
					uses_rs1 = 1'b1;
					imm = {{20{ifid.instr.i_format.imm[11]}}, ifid.instr.i_format.imm};
				end
				opc_store: begin
					ctrl.mem_write = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					uses_rs1 = 1'b1;
					uses_rs2 = 1'b1;
					imm = {{20{ifid.instr.s_format.imm_hi[6]}}, ifid.instr.s_format.imm_hi,
						ifid.instr.s_format.imm_lo};
				end
				opc_branch: begin
					ctrl.branch = 1'b1;
					ctrl.alu_op = alu_sub;
					uses_rs1 = 1'b1;
					uses_rs2 = 1'b1;
					imm = {{19{ifid.instr.b_format.imm_12}}, ifid.instr.b_format.imm_12,
						ifid.instr.b_format.imm_11, ifid.instr.b_format.imm_10_5,
						ifid.instr.b_format.imm_4_1, 1'b0};
				end
				opc_jal: begin
					ctrl.reg_write = 1'b1;
					ctrl.link = 1'b1;
					imm = {{11{ifid.instr.j_format.imm_20}}, ifid.instr.j_format.imm_20,
						ifid.instr.j_format.imm_19_12, ifid.instr.j_format.imm_11,
						ifid.instr.j_format.imm_10_1, 1'b0};
				end
				default: ctrl = '0;
			endcase
		end
	end

	// load result not ready until it reaches memwb
	assign stall = idex.valid && idex.ctrl.mem_read && idex.rd != '0 &&
		((uses_rs1 && rs1 == idex.rd) || (uses_rs2 && rs2 == idex.rd));

	assign id_redirect.valid = ctrl.link;
	assign id_redirect.target = ifid.pc + imm;

	assign wb_en = memwb.valid && memwb.reg_write && memwb.rd != '0;

	always_ff @(posedge clock) begin
		if (wb_en) begin
			register_file[memwb.rd] <= memwb.wb_data;
		end
	end

	// x0 reads zero, a same-cycle write is passed straight through
	function automatic word_t read_reg(input reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wb_en && memwb.rd == addr) begin
			value = memwb.wb_data;
		end else begin
			value = register_file[addr];
		end
		return value;
	endfunction

	always_comb begin
		rs1_data = read_reg(rs1);
		rs2_data = read_reg(rs2);
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			idex <= '0;
		end else if (ex_redirect.valid || stall) begin
			idex.valid <= 1'b0;
			idex.ctrl <= '0;
		end else begin
			idex.valid <= ifid.valid;
			idex.pc <= ifid.pc;
			idex.ctrl <= ctrl;
			idex.rs1 <= rs1;
			idex.rs2 <= rs2;
			idex.rd <= rd;
			idex.rs1_data <= rs1_data;
			idex.rs2_data <= rs2_data;
			idex.imm <= imm;
		end
	end

	// jal reads no register, so it never waits behind a load
	no_stalled_jal: assert property (@(posedge clock) disable iff (!reset)
		!(stall && id_redirect.valid));

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input logic clock,
	input logic reset,
	input cpu_pkg::idex_t idex,
	output cpu_pkg::exmem_t exmem,
	input cpu_pkg::memwb_t memwb,
	output cpu_pkg::redirect_t ex_redirect
);
	import cpu_pkg::*;

	logic exmem_writes;
	logic memwb_writes;
	word_t fwd_a;
	word_t fwd_b;
	word_t op_a;
	word_t op_b;
	word_t result;

	// only real writers with a nonzero rd may forward
	assign exmem_writes = exmem.valid && exmem.ctrl.reg_write && exmem.rd != '0;
	assign memwb_writes = memwb.valid && memwb.reg_write && memwb.rd != '0;

	// nearer stage holds the younger value
	function automatic word_t pick(input logic from_exmem, input logic from_memwb,
		input word_t exmem_value, input word_t memwb_value, input word_t reg_value);
		word_t value;
		if (from_exmem) begin
			value = exmem_value;
		end else if (from_memwb) begin
			value = memwb_value;
		end else begin
			value = reg_value;
		end
		return value;
	endfunction

	assign fwd_a = pick(exmem_writes && exmem.rd == idex.rs1,
		memwb_writes && memwb.rd == idex.rs1, exmem.result, memwb.wb_data, idex.rs1_data);
	assign fwd_b = pick(exmem_writes && exmem.rd == idex.rs2,
		memwb_writes && memwb.rd == idex.rs2, exmem.result, memwb.wb_data, idex.rs2_data);

	// jal writes pc + 4 as its link value
	assign op_a = idex.ctrl.link ? idex.pc : fwd_a;
	assign op_b = idex.ctrl.link ? 32'd4 : (idex.ctrl.alu_src_imm ? idex.imm : fwd_b);

	always_comb begin
		case (idex.ctrl.alu_op)
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_and: result = op_a & op_b;
			alu_or: result = op_a | op_b;
			alu_xor: result = op_a ^ op_b;
			alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
			default: result = op_a + op_b;
		endcase
	end

	assign ex_redirect.valid = idex.valid && idex.ctrl.branch && fwd_a == fwd_b;
	assign ex_redirect.target = idex.pc + idex.imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			exmem <= '0;
		end else begin
			exmem.valid <= idex.valid;
			exmem.ctrl <= idex.ctrl;
			exmem.rd <= idex.rd;
			exmem.result <= result;
			exmem.store_data <= fwd_b;
		end
	end

	// x0 operands stay zero through decode and forwarding alike
	x0_operand_a: assert property (@(posedge clock) disable iff (!reset)
		(idex.valid && idex.rs1 == '0) |-> fwd_a == '0);
	x0_operand_b: assert property (@(posedge clock) disable iff (!reset)
		(idex.valid && idex.rs2 == '0) |-> fwd_b == '0);

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
	input logic clock,
	input logic reset,
	input cpu_pkg::exmem_t exmem,
	output cpu_pkg::word_t data_addr,
	output cpu_pkg::word_t data_wdata,
	output logic data_wen,
	output logic data_ren,
	input cpu_pkg::word_t data_rdata,
	output cpu_pkg::memwb_t memwb
);
	import cpu_pkg::*;

	assign data_addr = exmem.result;
	assign data_wdata = exmem.store_data;
	assign data_wen = exmem.valid && exmem.ctrl.mem_write;
	assign data_ren = exmem.valid && exmem.ctrl.mem_read;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			memwb <= '0;
		end else begin
			memwb.valid <= exmem.valid;
			memwb.reg_write <= exmem.ctrl.reg_write;
			memwb.rd <= exmem.rd;
			// read data arrives in the same cycle as the address
			memwb.wb_data <= exmem.ctrl.mem_read ? data_rdata : exmem.result;
		end
	end

	// decode never marks one instruction as both load and store
	one_strobe: assert property (@(posedge clock) disable iff (!reset)
		!(data_wen && data_ren));

endmodule

// ==== src/cpu.sv ====
`timescale 1ns/1ps

module cpu #(
	parameter cpu_pkg::word_t reset_pc = 32'h0000_0000
) (
	input logic clock,
	input logic reset,
	output cpu_pkg::word_t instr_addr,
	input cpu_pkg::word_t instr_data,
	output cpu_pkg::word_t data_addr,
	output cpu_pkg::word_t data_wdata,
	output logic data_wen,
	output logic data_ren,
	input cpu_pkg::word_t data_rdata
);
	import cpu_pkg::*;

	ifid_t ifid;
	idex_t idex;
	exmem_t exmem;
	memwb_t memwb;
	logic stall;
	redirect_t id_redirect;
	redirect_t ex_redirect;

	fetch_stage #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.id_redirect(id_redirect),
		.ex_redirect(ex_redirect),
		.instr_addr(instr_addr),
		.instr_data(instr_data),
		.ifid(ifid)
	);

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.ifid(ifid),
		.ex_redirect(ex_redirect),
		.memwb(memwb),
		.idex(idex),
		.stall(stall),
		.id_redirect(id_redirect)
	);

	execute_stage u_execute (
		.clock(clock),
		.reset(reset),
		.idex(idex),
		.exmem(exmem),
		.memwb(memwb),
		.ex_redirect(ex_redirect)
	);

	memory_stage u_memory (
		.clock(clock),
		.reset(reset),
		.exmem(exmem),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_rdata(data_rdata),
		.memwb(memwb)
	);

endmodule

// ==== testbench/tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory (
	input logic clock,
	input cpu_pkg::word_t instr_addr,
	output cpu_pkg::word_t instr_data,
	input cpu_pkg::word_t data_addr,
	input cpu_pkg::word_t data_wdata,
	input logic data_wen,
	input logic data_ren,
	output cpu_pkg::word_t data_rdata
);
	import cpu_pkg::*;

	word_t rom [256];
	word_t ram [256];
	word_t store_addr [$];
	word_t store_data [$];

	// both ports read combinationally
	assign instr_data = rom[instr_addr[9:2]];
	// read data only meaningful under data_ren
	assign data_rdata = data_ren ? ram[data_addr[9:2]] : 'x;

	always @(posedge clock) begin
		if (data_wen) begin
			ram[data_addr[9:2]] <= data_wdata;
			store_addr.push_back(data_addr);
			store_data.push_back(data_wdata);
		end
	end

	task automatic load_rom(input int idx, input word_t value);
		rom[idx[7:0]] = value;
	endtask

	task automatic write_ram(input int idx, input word_t value);
		ram[idx[7:0]] = value;
	endtask

	task automatic clear_stores();
		store_addr.delete();
		store_data.delete();
	endtask

	function automatic int store_count();
		return store_addr.size();
	endfunction

	task automatic get_store(input int idx, output word_t addr, output word_t data);
		addr = store_addr[idx];
		data = store_data[idx];
	endtask

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	logic clock;
	logic reset;
	word_t instr_addr;
	word_t instr_data;
	word_t data_addr;
	word_t data_wdata;
	word_t data_rdata;
	logic data_wen;
	logic data_ren;

	word_t program_words [256];
	int program_len;
	word_t exp_addr [$];
	word_t exp_data [$];
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int budget_cycles = 20;
	int cycle_count = 0;
	event check_now;
	bit check_done;

	cpu #(
		.reset_pc(32'h0000_0000)
	) u_dut (
		.clock(clock),
		.reset(reset),
		.instr_addr(instr_addr),
		.instr_data(instr_data),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_rdata(data_rdata)
	);

	tb_memory u_memory (
		.clock(clock),
		.instr_addr(instr_addr),
		.instr_data(instr_data),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_rdata(data_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// every word of the RAM starts different
	function automatic word_t ram_pattern(input int idx);
		return 32'h5a5a_0000 + word_t'(idx) * 32'h0101_0007;
	endfunction

	task automatic compare(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("error: %s = %h, expected %h", name, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
		input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		instr_u w;
		w.r_format.funct7 = f7;
		w.r_format.rs2 = rs2;
		w.r_format.rs1 = rs1;
		w.r_format.funct3 = f3;
		w.r_format.rd = rd;
		w.r_format.opcode = opc_op;
		return w;
	endfunction

	function automatic word_t i_type(input opcode_e opc, input reg_addr_t rd,
		input reg_addr_t rs1, input int imm);
		instr_u w;
		w.i_format.imm = imm[11:0];
		w.i_format.rs1 = rs1;
		w.i_format.funct3 = (opc == opc_load) ? 3'b010 : 3'b000;
		w.i_format.rd = rd;
		w.i_format.opcode = opc;
		return w;
	endfunction

	function automatic word_t s_type(input reg_addr_t rs1, input reg_addr_t rs2, input int imm);
		instr_u w;
		w.s_format.imm_hi = imm[11:5];
		w.s_format.rs2 = rs2;
		w.s_format.rs1 = rs1;
		w.s_format.funct3 = 3'b010;
		w.s_format.imm_lo = imm[4:0];
		w.s_format.opcode = opc_store;
		return w;
	endfunction

	function automatic word_t b_type(input reg_addr_t rs1, input reg_addr_t rs2, input int off);
		instr_u w;
		w.b_format.imm_12 = off[12];
		w.b_format.imm_10_5 = off[10:5];
		w.b_format.rs2 = rs2;
		w.b_format.rs1 = rs1;
		w.b_format.funct3 = 3'b000;
		w.b_format.imm_4_1 = off[4:1];
		w.b_format.imm_11 = off[11];
		w.b_format.opcode = opc_branch;
		return w;
	endfunction

	function automatic word_t j_type(input reg_addr_t rd, input int off);
		instr_u w;
		w.j_format.imm_20 = off[20];
		w.j_format.imm_10_1 = off[10:1];
		w.j_format.imm_11 = off[11];
		w.j_format.imm_19_12 = off[19:12];
		w.j_format.rd = rd;
		w.j_format.opcode = opc_jal;
		return w;
	endfunction

	function automatic int rand_imm();
		return int'($urandom_range(4095, 0)) - 2048;
	endfunction

	task automatic emit(input word_t w);
		program_words[program_len[7:0]] = w;
		program_len++;
	endtask

	// nops keep the final self-loop clear of any branch shadow
	task automatic finish_program();
		repeat (3) emit(nop_instr);
		emit(j_type(5'd0, 0));
	endtask

	// ISA-level model, one instruction per step until the self-loop
	function automatic void run_reference();
		word_t regs [32];
		word_t mem [256];
		instr_u w;
		word_t pc;
		word_t a;
		word_t b;
		word_t addr;
		word_t res;
		logic done;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < 256; i++) mem[i] = ram_pattern(i);
		pc = '0;
		done = 1'b0;
		for (int step = 0; step < 2000 && !done; step++) begin
			w = program_words[pc[9:2]];
			a = regs[w.r_format.rs1];
			b = regs[w.r_format.rs2];
			res = '0;
			case (w.r_format.opcode)
				opc_op: begin
					case (w.r_format.funct3)
						3'b000: res = w.r_format.funct7[5] ? a - b : a + b;
						3'b010: res = {31'b0, $signed(a) < $signed(b)};
						3'b100: res = a ^ b;
						3'b110: res = a | b;
						default: res = a & b;
					endcase
					regs[w.r_format.rd] = res;
					pc = pc + 4;
				end
				opc_op_imm: begin
					regs[w.i_format.rd] = a + {{20{w.i_format.imm[11]}}, w.i_format.imm};
					pc = pc + 4;
				end
				opc_load: begin
					addr = a + {{20{w.i_format.imm[11]}}, w.i_format.imm};
					regs[w.i_format.rd] = mem[addr[9:2]];
					pc = pc + 4;
				end
				opc_store: begin
					addr = a + {{20{w.s_format.imm_hi[6]}}, w.s_format.imm_hi, w.s_format.imm_lo};
					mem[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					pc = pc + 4;
				end
				opc_branch: begin
					if (a == b) begin
						pc = pc + {{19{w.b_format.imm_12}}, w.b_format.imm_12, w.b_format.imm_11,
							w.b_format.imm_10_5, w.b_format.imm_4_1, 1'b0};
					end else begin
						pc = pc + 4;
					end
				end
				opc_jal: begin
					res = {{11{w.j_format.imm_20}}, w.j_format.imm_20, w.j_format.imm_19_12,
						w.j_format.imm_11, w.j_format.imm_10_1, 1'b0};
					if (res == '0) begin
						done = 1'b1;
					end else begin
						regs[w.j_format.rd] = pc + 4;
						pc = pc + res;
					end
				end
				default: pc = pc + 4;
			endcase
			regs[0] = '0;
		end
	endfunction

	// each op result stored from memwb, its follower forwarded from exmem
	task automatic build_alu();
		reg_addr_t ra;
		reg_addr_t rb;
		logic [6:0] f7;
		logic [2:0] f3;
		program_len = 0;
		// x1 negative and x2 not, so slt sees the sign
		emit(i_type(opc_op_imm, 5'd1, 5'd0, -1 - int'($urandom_range(2047, 0))));
		emit(i_type(opc_op_imm, 5'd2, 5'd0, int'($urandom_range(2047, 0))));
		for (int k = 0; k < 6; k++) begin
			ra = reg_addr_t'(5 + $urandom_range(7, 0));
			rb = reg_addr_t'(13 + $urandom_range(7, 0));
			f7 = (k == 1) ? 7'b0100000 : 7'b0000000;
			case (k)
				0, 1: f3 = 3'b000;
				2: f3 = 3'b111;
				3: f3 = 3'b110;
				4: f3 = 3'b100;
				default: f3 = 3'b010;
			endcase
			emit(r_type(f7, f3, ra, 5'd1, 5'd2));
			emit(r_type(f7, f3, rb, ra, 5'd1));
			emit(s_type(5'd0, ra, 64 + 16 * k));
			emit(s_type(5'd0, rb, 68 + 16 * k));
		end
		finish_program();
	endtask

	task automatic build_load_use();
		program_len = 0;
		emit(i_type(opc_op_imm, 5'd1, 5'd0, rand_imm()));
		emit(s_type(5'd0, 5'd1, 256));
		emit(i_type(opc_load, 5'd7, 5'd0, 256));
		emit(r_type(7'b0, 3'b000, 5'd8, 5'd7, 5'd7));
		emit(s_type(5'd0, 5'd8, 260));
		// store data waits on the load too
		emit(i_type(opc_load, 5'd9, 5'd0, 40));
		emit(s_type(5'd0, 5'd9, 264));
		emit(i_type(opc_load, 5'd10, 5'd0, 44));
		emit(i_type(opc_op_imm, 5'd11, 5'd10, 1));
		emit(s_type(5'd0, 5'd11, 268));
		finish_program();
	endtask

	task automatic build_branch();
		program_len = 0;
		emit(i_type(opc_op_imm, 5'd1, 5'd0, 5));
		emit(i_type(opc_op_imm, 5'd2, 5'd0, 5));
		emit(b_type(5'd1, 5'd2, 12));
		emit(s_type(5'd0, 5'd1, 300));
		emit(s_type(5'd0, 5'd2, 304));
		emit(s_type(5'd0, 5'd1, 308));
		emit(b_type(5'd1, 5'd0, 8));
		emit(s_type(5'd0, 5'd2, 312));
		emit(s_type(5'd0, 5'd1, 316));
		finish_program();
	endtask

	task automatic build_jal();
		program_len = 0;
		emit(i_type(opc_op_imm, 5'd3, 5'd0, rand_imm()));
		emit(j_type(5'd1, 12));
		emit(s_type(5'd0, 5'd3, 400));
		emit(s_type(5'd0, 5'd3, 404));
		emit(s_type(5'd0, 5'd1, 408));
		emit(s_type(5'd0, 5'd3, 412));
		finish_program();
	endtask

	task automatic run_test(input string name);
		word_t end_addr;
		test_errors = 0;
		end_addr = word_t'((program_len - 1) * 4);
		budget_cycles += program_len * 4 + 50 + 16;
		@(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			u_memory.load_rom(i, (i < program_len) ? program_words[i] : nop_instr);
			u_memory.write_ram(i, ram_pattern(i));
		end
		u_memory.clear_stores();
		repeat (16) begin
			@(negedge clock);
			compare("data_wen", {31'b0, data_wen}, '0);
			compare("data_ren", {31'b0, data_ren}, '0);
			compare("instr_addr", instr_addr, 32'h0000_0000);
		end
		@(posedge clock);
		reset <= 1'b1;
		do @(negedge clock); while (instr_addr !== end_addr);
		// let the last stores drain
		repeat (8) @(negedge clock);
		run_reference();
		check_done = 1'b0;
		-> check_now;
		wait (check_done);
		tests_run++;
		if (test_errors != 0) tests_failed++;
		$display("test %s: %0d stores expected, %0d errors", name, exp_addr.size(), test_errors);
	endtask

	initial begin : compare_stores
		int n;
		word_t addr;
		word_t data;
		forever begin
			@(check_now);
			n = u_memory.store_count();
			if (n != exp_addr.size()) begin
				$display("wrong number of stores: saw %0d, expected %0d", n, exp_addr.size());
				errors++;
				test_errors++;
			end
			for (int i = 0; i < n && i < exp_addr.size(); i++) begin
				u_memory.get_store(i, addr, data);
				compare("data_addr", addr, exp_addr[i]);
				compare("data_wdata", data, exp_data[i]);
			end
			check_done = 1'b1;
		end
	end

	initial begin
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count > budget_cycles) begin
				$display("watchdog: run did not finish within %0d cycles", budget_cycles);
				$display("TEST RESULT: FAIL");
				$finish;
			end
		end
	end

	initial begin
		void'($urandom(5));
		reset = 1'b0;
		build_alu();
		run_test("alu_forwarding");
		build_load_use();
		run_test("load_use");
		build_branch();
		run_test("beq");
		build_jal();
		run_test("jal");
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== cpu.f ====
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu.sv
testbench/tb_memory.sv
testbench/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f cpu.f \
	--top-module cpu_tb \
	-o Vcpu_tb

./obj_dir/Vcpu_tb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
